// File: oledInitPkg.sv
`default_nettype none

package oledInitPkg;

    // control flags sit above the byte on the SPI data word
    typedef struct packed {
        logic [1:0] ctrl;
        logic [7:0] payload;
    } cmdWord_t;

    // command or argument byte
    localparam logic [1:0] CTRL_CMD = 2'b00;

    // bus parked before the first command
    localparam logic [1:0] CTRL_IDLE = 2'b11;

    localparam cmdWord_t IDLE_WORD = '{
        ctrl:    CTRL_IDLE,
        payload: 8'h00
    };

    // bytes in the power-up sequence, display on last
    localparam int SEQ_LEN = 37;

    typedef logic [5:0] stepIdx_t; // 0 .. SEQ_LEN-1

endpackage

`default_nettype wire

// File: oledResetTimer.sv
`timescale 1ns/1ps
`default_nettype none

module oledResetTimer #(
    parameter int RESET_CYCLES = 1000000
) (
    input  logic CLK,
    input  logic RST_N,
    output logic panelReady
);

    localparam int CNT_W = (RESET_CYCLES < 1) ? 1 : $clog2(RESET_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(RESET_CYCLES);

    logic [CNT_W-1:0] count;
    logic             countHit;

    assign countHit = (count == CNT_MAX);

    // counter stops at the limit, ready goes high one edge after the last count
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            count      <= '0;
            panelReady <= 1'b0;
        end else if (countHit) begin
            panelReady <= 1'b1; // panel reset released
        end else begin
            count <= count + 1'b1;
        end
    end

    // panel must not be pushed back into reset once released
    property pReadySticky;
        @(posedge CLK) disable iff (!RST_N)
        panelReady |=> panelReady;
    endproperty

    aReadySticky: assert property (pReadySticky)
        else $error("panelReady fell after release");

endmodule

`default_nettype wire

// File: oledCmdRom.sv
`timescale 1ns/1ps
`default_nettype none

module oledCmdRom import oledInitPkg::*; (
    input  stepIdx_t step,
    output cmdWord_t word
);

    function automatic cmdWord_t cmd(input logic [7:0] b);
        return '{ctrl: CTRL_CMD, payload: b};
    endfunction

    // SSD1331 power-up table, commands followed by their arguments
    always_comb begin
        case (step)
            6'd0:  word = cmd(8'hAE); // display off
            6'd1:  word = cmd(8'h81); // contrast a, blue
            6'd2:  word = cmd(8'hFF);
            6'd3:  word = cmd(8'h82); // contrast b, green
            6'd4:  word = cmd(8'hFF);
            6'd5:  word = cmd(8'h83); // contrast c, red
            6'd6:  word = cmd(8'hFF);
            6'd7:  word = cmd(8'h87); // master current
            6'd8:  word = cmd(8'h06);
            6'd9:  word = cmd(8'h8A); // precharge speed a
            6'd10: word = cmd(8'h64);
            6'd11: word = cmd(8'h8B); // precharge speed b
            6'd12: word = cmd(8'h78);
            6'd13: word = cmd(8'h8C); // precharge speed c
            6'd14: word = cmd(8'h64);
            6'd15: word = cmd(8'hA0); // remap and colour depth
            6'd16: word = cmd(8'h72);
            6'd17: word = cmd(8'hA1); // start line
            6'd18: word = cmd(8'h00);
            6'd19: word = cmd(8'hA2); // display offset
            6'd20: word = cmd(8'h00);
            6'd21: word = cmd(8'hA4); // normal display
            6'd22: word = cmd(8'hA8); // multiplex ratio
            6'd23: word = cmd(8'h3F);
            6'd24: word = cmd(8'hAD); // master config
            6'd25: word = cmd(8'h8E);
            6'd26: word = cmd(8'hB0); // power save mode
            6'd27: word = cmd(8'h00);
            6'd28: word = cmd(8'hB1); // phase period
            6'd29: word = cmd(8'h31);
            6'd30: word = cmd(8'hB3); // clock divider
            6'd31: word = cmd(8'hF0);
            6'd32: word = cmd(8'hBB); // precharge voltage
            6'd33: word = cmd(8'h3A);
            6'd34: word = cmd(8'hBE); // vcomh
            6'd35: word = cmd(8'h3E);
            6'd36: word = cmd(8'hAF); // display on
            default: word = IDLE_WORD; // out of range
        endcase
    end

endmodule

`default_nettype wire

// File: oledInitSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module oledInitSequencer import oledInitPkg::*; (
    input  logic     CLK,
    input  logic     RST_N,
    input  logic     start,
    input  logic     panelReady,
    input  logic     spiDone,
    input  cmdWord_t word,
    output stepIdx_t step,
    output logic     spiStart,
    output cmdWord_t spiData,
    output logic     done
);

    localparam stepIdx_t LAST_STEP = stepIdx_t'(SEQ_LEN - 1);

    logic active;
    logic accept;
    logic lastStep;

    assign active   = start && panelReady && !done; // low start freezes everything
    assign accept   = spiStart && spiDone;          // writer took the byte
    assign lastStep = (step == LAST_STEP);

    // send: load the table word and raise spiStart together
    // wait: hold both until spiDone, then drop spiStart for one cycle
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            step     <= '0;
            spiStart <= 1'b0;
            spiData  <= IDLE_WORD;
            done     <= 1'b0;
        end else if (active) begin
            if (accept) begin
                spiStart <= 1'b0;
                if (lastStep) begin
                    done <= 1'b1; // display on sent
                end else begin
                    step <= step + stepIdx_t'(1);
                end
            end else if (!spiStart) begin
                spiData  <= word;
                spiStart <= 1'b1;
            end
        end
    end

    // writer sees a steady request until it answers
    property pHoldUntilDone;
        @(posedge CLK) disable iff (!RST_N)
        (spiStart && !spiDone) |=> (spiStart && $stable(spiData));
    endproperty

    aHoldUntilDone: assert property (pHoldUntilDone)
        else $error("spiData or spiStart changed before spiDone");

    property pStepInRange;
        @(posedge CLK) disable iff (!RST_N)
        step <= LAST_STEP;
    endproperty

    aStepInRange: assert property (pStepInRange)
        else $error("step beyond end of table");

    // nothing goes out once the sequence is complete
    property pIdleAfterDone;
        @(posedge CLK) disable iff (!RST_N)
        !(spiStart && done);
    endproperty

    aIdleAfterDone: assert property (pIdleAfterDone)
        else $error("spiStart high after done");

endmodule

`default_nettype wire

// File: oledInit.sv
`timescale 1ns/1ps
`default_nettype none

module oledInit import oledInitPkg::*; #(
    parameter int RESET_CYCLES = 1000000
) (
    input  logic     CLK,
    input  logic     RST_N,
    input  logic     start,
    input  logic     spiDone,
    output logic     spiStart,
    output cmdWord_t spiData,
    output logic     done,
    output logic     oledRst
);

    logic     panelReady;
    stepIdx_t step;
    cmdWord_t word;

    oledResetTimer #(
        .RESET_CYCLES (RESET_CYCLES)
    ) uTimer (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .panelReady (panelReady)
    );

    // panel reset pin follows the timer directly
    assign oledRst = panelReady;

    oledCmdRom uRom (
        .step (step),
        .word (word)
    );

    oledInitSequencer uSeq (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .start      (start),
        .panelReady (panelReady),
        .spiDone    (spiDone),
        .word       (word),
        .step       (step),
        .spiStart   (spiStart),
        .spiData    (spiData),
        .done       (done)
    );

endmodule

`default_nettype wire

// File: tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
    output logic CLK,
    output logic RST_N
);

    initial CLK = 1'b0;

    always #5 CLK = ~CLK; // 10 ns period

    initial begin
        RST_N = 1'b0;
        repeat (3) @(posedge CLK);
        #1 RST_N = 1'b1; // released off the edge like every other input
    end

endmodule

`default_nettype wire

// File: oledInit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module oledInit_tb;

    localparam int RESET_CYCLES = 4;
    localparam int NUM_BYTES = 37;
    localparam int WAIT_LIMIT = 200;
    localparam logic [9:0] IDLE_WORD = 10'h300; // ctrl 11, byte 00
    localparam logic [1:0] CMD_CTRL = 2'b00;

    // SSD1331 power-up bytes in send order
    localparam logic [7:0] EXP_BYTES [0:NUM_BYTES-1] = '{
        8'hAE, 8'h81, 8'hFF, 8'h82, 8'hFF, 8'h83, 8'hFF, 8'h87, 8'h06, 8'h8A,
        8'h64, 8'h8B, 8'h78, 8'h8C, 8'h64, 8'hA0, 8'h72, 8'hA1, 8'h00, 8'hA2,
        8'h00, 8'hA4, 8'hA8, 8'h3F, 8'hAD, 8'h8E, 8'hB0, 8'h00, 8'hB1, 8'h31,
        8'hB3, 8'hF0, 8'hBB, 8'h3A, 8'hBE, 8'h3E, 8'hAF
    };

    logic        CLK;
    logic        RST_N;
    logic        start;
    logic        spiDone;
    logic        spiStart;
    logic [9:0]  spiData;
    logic        done;
    logic        oledRst;

    logic        accept;
    logic        seenStart;
    logic [9:0]  expWord;
    int          acceptCount;
    int          sinceRelease;
    logic [31:0] lcgState = 32'd75830;

    tbClockGen clkGen (
        .CLK   (CLK),
        .RST_N (RST_N)
    );

    oledInit #(
        .RESET_CYCLES (RESET_CYCLES)
    ) uut (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .start    (start),
        .spiDone  (spiDone),
        .spiStart (spiStart),
        .spiData  (spiData),
        .done     (done),
        .oledRst  (oledRst)
    );

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {17'd0, lcgState[30:16]};
    endfunction

    task automatic showMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        $display("Verification failed");
        $display("mismatch %s expected %0h actual %0h", name, expVal, actVal);
        $fatal(1, "stopped at first error");
    endtask

    task automatic stopWithReason(input string reason);
        $display("Verification failed");
        $display("%s", reason);
        $fatal(1, "stopped at first error");
    endtask

    assign accept = spiStart && spiDone && start; // the DUT takes the byte here

    always_comb begin
        if (acceptCount < NUM_BYTES) begin
            expWord = {CMD_CTRL, EXP_BYTES[acceptCount]};
        end else begin
            expWord = IDLE_WORD;
        end
    end

    // reference counters kept alongside the DUT
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            acceptCount  <= 0;
            seenStart    <= 1'b0;
            sinceRelease <= 0;
        end else begin
            if (accept) begin
                acceptCount <= acceptCount + 1;
            end
            if (spiStart) begin
                seenStart <= 1'b1;
            end
            if (sinceRelease < 1000) begin
                sinceRelease <= sinceRelease + 1;
            end
        end
    end

    aResetQuiet: assert property (@(posedge CLK)
        !RST_N |-> (!oledRst && !spiStart && !done))
        else stopWithReason("outputs active during reset");

    aRstRelease: assert property (@(posedge CLK) disable iff (!RST_N)
        oledRst == (sinceRelease > RESET_CYCLES))
        else showMismatch("rstRelease", 32'($sampled(sinceRelease) > RESET_CYCLES),
                          32'($sampled(oledRst)));

    aRstSticky: assert property (@(posedge CLK) disable iff (!RST_N)
        oledRst |=> oledRst)
        else stopWithReason("panel reset fell after release");

    aGate: assert property (@(posedge CLK) disable iff (!RST_N)
        (!spiStart && (!start || !oledRst)) |=> !spiStart)
        else stopWithReason("spiStart rose without start and panel ready");

    aFreeze: assert property (@(posedge CLK) disable iff (!RST_N)
        !start |=> ($stable(spiData) && $stable(spiStart) && $stable(done)))
        else stopWithReason("outputs moved while start was low");

    aIdleBeforeFirst: assert property (@(posedge CLK) disable iff (!RST_N)
        (!seenStart && !spiStart) |-> (spiData == IDLE_WORD))
        else showMismatch("idleWord", 32'(IDLE_WORD), 32'($sampled(spiData)));

    aByteOrder: assert property (@(posedge CLK) disable iff (!RST_N)
        accept |-> (spiData == expWord))
        else showMismatch("byteOrder", 32'($sampled(expWord)), 32'($sampled(spiData)));

    aHold: assert property (@(posedge CLK) disable iff (!RST_N)
        (spiStart && !accept) |=> (spiStart && $stable(spiData)))
        else stopWithReason("request changed before spiDone");

    aGap: assert property (@(posedge CLK) disable iff (!RST_N)
        accept |=> !spiStart)
        else stopWithReason("spiStart not dropped after spiDone");

    aRestart: assert property (@(posedge CLK) disable iff (!RST_N)
        (!spiStart && start && oledRst && !done) |=> spiStart)
        else stopWithReason("next byte not requested one cycle after the gap");

    aDoneAtLast: assert property (@(posedge CLK) disable iff (!RST_N)
        (accept && acceptCount == NUM_BYTES - 1) |=> done)
        else stopWithReason("done missing after the last byte");

    aDoneCount: assert property (@(posedge CLK) disable iff (!RST_N)
        done |-> (acceptCount == NUM_BYTES))
        else showMismatch("doneCount", 32'(NUM_BYTES), 32'($sampled(acceptCount)));

    aDoneSticky: assert property (@(posedge CLK) disable iff (!RST_N)
        done |=> done)
        else stopWithReason("done fell after completion");

    aQuietAfterDone: assert property (@(posedge CLK) disable iff (!RST_N)
        done |-> !spiStart)
        else stopWithReason("spiStart seen after done");

    // SPI writer model, answers each request after a random delay
    initial begin
        int waitCnt;
        int delay;
        spiDone = 1'b0;
        while (done !== 1'b1) begin
            waitCnt = 0;
            do begin
                @(posedge CLK);
                #1;
                waitCnt++;
                if (waitCnt > WAIT_LIMIT) begin
                    stopWithReason("writer model saw no spiStart in time");
                end
            end while (spiStart !== 1'b1 && done !== 1'b1);
            if (spiStart === 1'b1) begin
                delay = int'(lcgNext() % 8);
                repeat (delay) begin
                    @(posedge CLK);
                    #1;
                end
                spiDone = 1'b1;
                @(posedge CLK);
                #1;
                spiDone = 1'b0;
            end
        end
    end

    task automatic waitForAccepts(input int target);
        int waitCnt;
        waitCnt = 0;
        while (acceptCount < target) begin
            @(posedge CLK);
            #1;
            waitCnt++;
            if (waitCnt > WAIT_LIMIT) begin
                stopWithReason("timed out waiting for accepted bytes");
            end
        end
    endtask

    // called in the gap cycle, so spiStart is already low
    task automatic pauseStart();
        int pauseLen;
        pauseLen = 2 + int'(lcgNext() % 6);
        start = 1'b0;
        repeat (pauseLen) begin
            @(posedge CLK);
            #1;
        end
        start = 1'b1;
    endtask

    initial begin
        int waitCnt;
        start = 1'b0;
        waitCnt = 0;
        while (RST_N !== 1'b1) begin
            @(posedge CLK);
            #1;
            waitCnt++;
            if (waitCnt > WAIT_LIMIT) begin
                stopWithReason("system reset never released");
            end
        end
        waitCnt = 0;
        while (oledRst !== 1'b1) begin
            @(posedge CLK);
            #1;
            waitCnt++;
            if (waitCnt > WAIT_LIMIT) begin
                stopWithReason("panel reset never released");
            end
        end
        repeat (3) begin // panel ready but start still low
            @(posedge CLK);
            #1;
        end
        start = 1'b1;
        waitForAccepts(10);
        pauseStart();
        waitForAccepts(25);
        pauseStart();
        waitCnt = 0;
        while (done !== 1'b1) begin
            @(posedge CLK);
            #1;
            waitCnt++;
            if (waitCnt > WAIT_LIMIT) begin
                stopWithReason("done never rose");
            end
        end
        repeat (10) begin // watch for stray requests
            @(posedge CLK);
            #1;
        end
        if (acceptCount == NUM_BYTES) begin
            $display("Verification passed");
            $finish;
        end else begin
            showMismatch("totalCount", 32'(NUM_BYTES), 32'(acceptCount));
        end
    end

endmodule

`default_nettype wire

// File: compile.f
oledInitPkg.sv
oledResetTimer.sv
oledCmdRom.sv
oledInitSequencer.sv
oledInit.sv
tbClockGen.sv
oledInit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the OLED init testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module oledInit_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VoledInit_tb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

# the log decides the result
if grep -q "^Verification passed$" "$LOG"; then
    exit 0
else
    exit 1
fi
